/* pipePkg.sv */
`default_nettype none

package pipePkg;

    //////////////////////////////////////////////////
    // architectural sizes
    //////////////////////////////////////////////////

    // general purpose registers of the core
    localparam int gprCount = 32;

    // data or address word
    typedef logic [31:0] word;

    // register number, 0 means no write
    typedef logic [4:0] gprNum;

    //////////////////////////////////////////////////
    // load handling
    //////////////////////////////////////////////////

    // ldNone keeps the alu result
    typedef enum logic [2:0] {
        ldNone         = 3'd0,
        ldByteSigned   = 3'd1,
        ldByteUnsigned = 3'd2,
        ldHalfSigned   = 3'd3,
        ldHalfUnsigned = 3'd4,
        ldWord         = 3'd5
    } loadKind;

    // same memory word, seen as bytes or as halves
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } memWord;

    //////////////////////////////////////////////////
    // stage payloads
    //////////////////////////////////////////////////

    // one executed instruction
    typedef struct packed {
        word     pc;
        gprNum   writeNum;
        word     aluData;
        // for loads aluData is unused
        loadKind kind;
        // byte or half select
        logic [1:0] addrLow;
    } exResult;

    // what the writeback stage needs
    typedef struct packed {
        word   pc;
        gprNum writeNum;
        word   data;
    } wbEntry;

    // debug trace of one cycle
    typedef struct packed {
        word        pc;
        logic [3:0] wen;
        gprNum      wnum;
        word        wdata;
    } traceInfo;

endpackage

`default_nettype wire

/* resultStage.sv */
`timescale 1ns/100ps
`default_nettype none

module resultStage (
    input  wire                   clk,
    input  wire                   rst,
    // offer from execute
    input  wire                   exValid_i,
    input  wire pipePkg::exResult exOp_i,
    input  wire pipePkg::memWord  memData_i,
    // interlock from writeback
    input  wire                   wbOkToChange_i,
    output logic                  exAllowin_o,
    // entry towards writeback
    output logic                  rsValid_o,
    output pipePkg::wbEntry       rsEntry_o
);

    //////////////////////////////////////////////////
    // interlock
    //////////////////////////////////////////////////

    logic            rsValid;
    pipePkg::wbEntry rsEntry;
    logic            accept;

    // empty, or the held entry moves on this cycle
    assign exAllowin_o = !rsValid || wbOkToChange_i;
    assign accept      = exValid_i && exAllowin_o;

    always_ff @(posedge clk) begin
        if (!rst) begin
            rsValid <= 1'b0;
        end else if (exAllowin_o) begin
            // bubble in when nothing is offered
            rsValid <= exValid_i;
        end
    end

    //////////////////////////////////////////////////
    // load alignment
    //////////////////////////////////////////////////

    logic [7:0]   selByte;
    logic [15:0]  selHalf;
    pipePkg::word loadData;

    // byte by full offset, half by upper offset bit
    assign selByte = memData_i.bytes[exOp_i.addrLow];
    assign selHalf = memData_i.halves[exOp_i.addrLow[1]];

    always_comb begin
        case (exOp_i.kind)
            pipePkg::ldByteSigned:   loadData = {{24{selByte[7]}}, selByte};
            pipePkg::ldByteUnsigned: loadData = {24'b0, selByte};
            pipePkg::ldHalfSigned:   loadData = {{16{selHalf[15]}}, selHalf};
            pipePkg::ldHalfUnsigned: loadData = {16'b0, selHalf};
            pipePkg::ldWord:         loadData = memData_i;
            // not a load
            default:                 loadData = exOp_i.aluData;
        endcase
    end

    // payload only moves on acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            rsEntry.pc       <= exOp_i.pc;
            rsEntry.writeNum <= exOp_i.writeNum;
            rsEntry.data     <= loadData;
        end
    end

    assign rsValid_o = rsValid;
    assign rsEntry_o = rsEntry;

    // halves are always naturally aligned
    halfAligned: assert property (@(posedge clk) disable iff (!rst)
        accept && (exOp_i.kind inside {pipePkg::ldHalfSigned, pipePkg::ldHalfUnsigned})
        |-> !exOp_i.addrLow[0]);

endmodule

`default_nettype wire

/* writebackStage.sv */
`timescale 1ns/100ps
`default_nettype none

module writebackStage (
    input  wire                  clk,
    input  wire                  rst,
    // from result stage
    input  wire                  rsValid_i,
    input  wire pipePkg::wbEntry rsEntry_i,
    // downstream allowin
    input  wire                  commitAllowin_i,
    output logic                 wbOkToChange_o,
    // forwarding and register file write
    output logic                 wbValid_o,
    output pipePkg::gprNum       wbWriteNum_o,
    output pipePkg::word         wbForwardData_o,
    output logic                 wbWriteEnable_o,
    // debug trace
    output pipePkg::traceInfo    trace_o
);

    //////////////////////////////////////////////////
    // segment register
    //////////////////////////////////////////////////

    logic            hasData;
    pipePkg::wbEntry entry;
    logic            needUpdate;
    logic            needClear;
    logic            retire;

    // empty or retiring this cycle
    assign wbOkToChange_o = !hasData || commitAllowin_i;
    assign retire         = hasData && commitAllowin_i;

    assign needUpdate = wbOkToChange_o && rsValid_i;
    // nothing arriving, so drop the old entry
    assign needClear  = wbOkToChange_o && !rsValid_i;

    always_ff @(posedge clk) begin
        if (!rst || needClear) begin
            entry <= '0;
        end else if (needUpdate) begin
            entry <= rsEntry_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            hasData <= 1'b0;
        end else if (wbOkToChange_o) begin
            hasData <= rsValid_i;
        end
    end

    //////////////////////////////////////////////////
    // forwarding and write
    //////////////////////////////////////////////////

    assign wbValid_o       = hasData;
    assign wbWriteNum_o    = entry.writeNum;
    assign wbForwardData_o = entry.data;
    // register 0 is never written
    assign wbWriteEnable_o = (|entry.writeNum) && retire;

    //////////////////////////////////////////////////
    // debug trace
    //////////////////////////////////////////////////

    pipePkg::traceInfo traceStage;

    // sampled on the register file write edge
    always_ff @(posedge clk) begin
        if (!rst) begin
            traceStage <= '0;
        end else begin
            traceStage.pc    <= entry.pc;
            traceStage.wen   <= {4{wbWriteEnable_o}};
            traceStage.wnum  <= entry.writeNum;
            traceStage.wdata <= entry.data;
        end
    end

    // trace shows up one cycle behind the write
    always_ff @(posedge clk) begin
        if (!rst) begin
            trace_o <= '0;
        end else begin
            trace_o <= traceStage;
        end
    end

    // a traced write always names a real register
    traceNoZero: assert property (@(posedge clk) disable iff (!rst)
        (|trace_o.wen) |-> (trace_o.wnum != '0));

    // held entry must not change under back-pressure
    holdStable: assert property (@(posedge clk) disable iff (!rst)
        hasData && !commitAllowin_i |=> hasData && $stable(entry));

endmodule

`default_nettype wire

/* regFile.sv */
`timescale 1ns/100ps
`default_nettype none

module regFile (
    input  wire                 clk,
    input  wire                 rst,
    // write port
    input  wire                 we_i,
    input  wire pipePkg::gprNum wNum_i,
    input  wire pipePkg::word   wData_i,
    // read ports
    input  wire pipePkg::gprNum rNumA_i,
    input  wire pipePkg::gprNum rNumB_i,
    output pipePkg::word        rDataA_o,
    output pipePkg::word        rDataB_o
);

    //////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////

    pipePkg::word regs [pipePkg::gprCount];

    always_ff @(posedge clk) begin
        if (!rst) begin
            // whole file starts at zero
            for (int i = 0; i < pipePkg::gprCount; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (wNum_i != '0)) begin
            // writes to register 0 are dropped
            regs[wNum_i] <= wData_i;
        end
    end

    //////////////////////////////////////////////////
    // reads
    //////////////////////////////////////////////////

    // combinational, no bypass here
    assign rDataA_o = regs[rNumA_i];
    assign rDataB_o = regs[rNumB_i];

    // register 0 stays hardwired to zero
    zeroReg: assert property (@(posedge clk) disable iff (!rst)
        regs[0] == '0);

endmodule

`default_nettype wire

/* operandBypass.sv */
`timescale 1ns/100ps
`default_nettype none

module operandBypass (
    input  wire pipePkg::gprNum  rNumA_i,
    input  wire pipePkg::gprNum  rNumB_i,
    // result stage, youngest
    input  wire                  rsValid_i,
    input  wire pipePkg::wbEntry rsEntry_i,
    // writeback stage
    input  wire                  wbValid_i,
    input  wire pipePkg::gprNum  wbWriteNum_i,
    input  wire pipePkg::word    wbForwardData_i,
    // architectural values
    input  wire pipePkg::word    rfDataA_i,
    input  wire pipePkg::word    rfDataB_i,
    output pipePkg::word         rdDataA_o,
    output pipePkg::word         rdDataB_o
);

    //////////////////////////////////////////////////
    // port a
    //////////////////////////////////////////////////

    always_comb begin
        if (rNumA_i == '0) begin
            // register 0 is hardwired
            rdDataA_o = '0;
        end else if (rsValid_i && (rsEntry_i.writeNum == rNumA_i)) begin
            // youngest in flight
            rdDataA_o = rsEntry_i.data;
        end else if (wbValid_i && (wbWriteNum_i == rNumA_i)) begin
            // written at the coming edge
            rdDataA_o = wbForwardData_i;
        end else begin
            rdDataA_o = rfDataA_i;
        end
    end

    //////////////////////////////////////////////////
    // port b
    //////////////////////////////////////////////////

    always_comb begin
        if (rNumB_i == '0) begin
            rdDataB_o = '0;
        end else if (rsValid_i && (rsEntry_i.writeNum == rNumB_i)) begin
            rdDataB_o = rsEntry_i.data;
        end else if (wbValid_i && (wbWriteNum_i == rNumB_i)) begin
            rdDataB_o = wbForwardData_i;
        end else begin
            // nothing newer in flight
            rdDataB_o = rfDataB_i;
        end
    end

endmodule

`default_nettype wire

/* pipeTail.sv */
`timescale 1ns/100ps
`default_nettype none

module pipeTail (
    input  wire                   clk,
    input  wire                   rst,
    // execute side
    input  wire                   exValid_i,
    input  wire pipePkg::exResult exOp_i,
    input  wire pipePkg::memWord  memData_i,
    output logic                  exAllowin_o,
    // commit side
    input  wire                   commitAllowin_i,
    // operand read ports
    input  wire pipePkg::gprNum   rdNumA_i,
    input  wire pipePkg::gprNum   rdNumB_i,
    output pipePkg::word          rdDataA_o,
    output pipePkg::word          rdDataB_o,
    // debug trace
    output pipePkg::traceInfo     trace_o
);

    //////////////////////////////////////////////////
    // stage wiring
    //////////////////////////////////////////////////

    logic            rsValid;
    pipePkg::wbEntry rsEntry;
    logic            wbOkToChange;
    logic            wbValid;
    pipePkg::gprNum  wbWriteNum;
    pipePkg::word    wbForwardData;
    logic            wbWriteEnable;
    pipePkg::word    rfDataA;
    pipePkg::word    rfDataB;

    resultStage uResult (
        .clk            (clk),
        .rst            (rst),
        .exValid_i      (exValid_i),
        .exOp_i         (exOp_i),
        .memData_i      (memData_i),
        .wbOkToChange_i (wbOkToChange),
        .exAllowin_o    (exAllowin_o),
        .rsValid_o      (rsValid),
        .rsEntry_o      (rsEntry)
    );

    writebackStage uWriteback (
        .clk             (clk),
        .rst             (rst),
        .rsValid_i       (rsValid),
        .rsEntry_i       (rsEntry),
        .commitAllowin_i (commitAllowin_i),
        .wbOkToChange_o  (wbOkToChange),
        .wbValid_o       (wbValid),
        .wbWriteNum_o    (wbWriteNum),
        .wbForwardData_o (wbForwardData),
        .wbWriteEnable_o (wbWriteEnable),
        .trace_o         (trace_o)
    );

    //////////////////////////////////////////////////
    // registers and operand reads
    //////////////////////////////////////////////////

    regFile uRegFile (
        .clk      (clk),
        .rst      (rst),
        .we_i     (wbWriteEnable),
        .wNum_i   (wbWriteNum),
        .wData_i  (wbForwardData),
        .rNumA_i  (rdNumA_i),
        .rNumB_i  (rdNumB_i),
        .rDataA_o (rfDataA),
        .rDataB_o (rfDataB)
    );

    // in-flight values override the register file
    operandBypass uBypass (
        .rNumA_i         (rdNumA_i),
        .rNumB_i         (rdNumB_i),
        .rsValid_i       (rsValid),
        .rsEntry_i       (rsEntry),
        .wbValid_i       (wbValid),
        .wbWriteNum_i    (wbWriteNum),
        .wbForwardData_i (wbForwardData),
        .rfDataA_i       (rfDataA),
        .rfDataB_i       (rfDataB),
        .rdDataA_o       (rdDataA_o),
        .rdDataB_o       (rdDataB_o)
    );

endmodule

`default_nettype wire

/* tbClock.sv */
`timescale 1ns/100ps
`default_nettype none

module tbClock (
    output logic clk_o
);

    // free running, 4 ns period, starts low
    initial begin
        clk_o = 1'b0;
        forever begin
            #2 clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

/* pipeTail_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module pipeTail_tb;

    localparam int instrTotal = 600;
    // commit held high from here on
    localparam int steadyFrom = 450;
    // eight cycles per instruction at worst, plus reset and drain
    localparam int cycleLimit = instrTotal * 8 + 100;

    typedef struct packed {
        pipePkg::wbEntry entry;
        int              acceptEdge;
        int              dueEdge;
        logic            steady;
    } flight;

    logic              clk;
    logic              rst;
    logic              exValid;
    pipePkg::exResult  exOp;
    pipePkg::memWord   memData;
    logic              exAllowin;
    logic              commitAllowin;
    pipePkg::gprNum    rdNumA;
    pipePkg::gprNum    rdNumB;
    pipePkg::word      rdDataA;
    pipePkg::word      rdDataB;
    pipePkg::traceInfo trace;

    // reference model state
    pipePkg::word arch [pipePkg::gprCount];
    flight        mRs;
    flight        mWb;
    logic         mRsV;
    logic         mWbV;
    flight        traceQ [$];
    logic         expAllowin;
    logic         offerAccepted = 1'b0;
    logic         steadyMode;
    int           occupied = 0;
    int           edgeCount = 0;
    int           errors = 0;
    int           acceptedCount = 0;
    int           tracedCount = 0;
    int           zeroRetired = 0;
    int           offersMade;
    logic [31:0]  lfsr;
    pipePkg::word nextPc;

    tbClock uClock (.clk_o(clk));

    pipeTail dut (
        .clk             (clk),
        .rst             (rst),
        .exValid_i       (exValid),
        .exOp_i          (exOp),
        .memData_i       (memData),
        .exAllowin_o     (exAllowin),
        .commitAllowin_i (commitAllowin),
        .rdNumA_i        (rdNumA),
        .rdNumB_i        (rdNumB),
        .rdDataA_o       (rdDataA),
        .rdDataB_o       (rdDataB),
        .trace_o         (trace)
    );

    //////////////////////////////////////////////////
    // random source and expected values
    //////////////////////////////////////////////////

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    // byte by offset, half by upper offset bit
    function automatic pipePkg::word alignLoad(input pipePkg::exResult op,
                                               input pipePkg::word mem);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(mem >> (8 * op.addrLow));
        h = 16'(mem >> (16 * op.addrLow[1]));
        case (op.kind)
            pipePkg::ldByteSigned:   return {{24{b[7]}}, b};
            pipePkg::ldByteUnsigned: return {24'h0, b};
            pipePkg::ldHalfSigned:   return {{16{h[15]}}, h};
            pipePkg::ldHalfUnsigned: return {16'h0, h};
            pipePkg::ldWord:         return mem;
            default:                 return op.aluData;
        endcase
    endfunction

    // youngest in-flight value wins over the model registers
    function automatic pipePkg::word expectRead(input pipePkg::gprNum n);
        if (n == '0) return '0;
        if (mRsV && mRs.entry.writeNum == n) return mRs.entry.data;
        if (mWbV && mWb.entry.writeNum == n) return mWb.entry.data;
        return arch[n];
    endfunction

    task automatic compareWord(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    task automatic buildOffer(output pipePkg::exResult op, output pipePkg::memWord mem);
        op.pc = nextPc;
        nextPc = nextPc + 4;
        // register 0 about one time in eight, low registers favoured
        if (takeBits(3) == 0) op.writeNum = '0;
        else if (takeBits(1) == 1) op.writeNum = 5'(takeBits(3) + 1);
        else op.writeNum = 5'(takeBits(5) % 31 + 1);
        op.aluData = takeBits(32);
        op.kind = pipePkg::loadKind'(3'(takeBits(3) % 6));
        if (op.kind inside {pipePkg::ldByteSigned, pipePkg::ldByteUnsigned}) begin
            op.addrLow = 2'(takeBits(2));
        end else if (op.kind inside {pipePkg::ldHalfSigned, pipePkg::ldHalfUnsigned}) begin
            op.addrLow = {1'(takeBits(1)), 1'b0};
        end else begin
            op.addrLow = 2'b00;
        end
        mem = takeBits(32);
    endtask

    task automatic driveCycle();
        pipePkg::exResult op;
        pipePkg::memWord  mem;
        if (acceptedCount >= steadyFrom) steadyMode = 1'b1;
        // an offer is held until it is taken
        if (!exValid || offerAccepted) begin
            if (offersMade < instrTotal && takeBits(2) != 0) begin
                buildOffer(op, mem);
                exOp <= op;
                memData <= mem;
                exValid <= 1'b1;
                offersMade++;
            end else begin
                exValid <= 1'b0;
            end
        end
        commitAllowin <= steadyMode ? 1'b1 : (takeBits(2) != 0);
        rdNumA <= 5'(takeBits(5));
        rdNumB <= 5'(takeBits(5));
    endtask

    initial begin
        lfsr = 32'h4245;
        rst = 1'b0;
        exValid = 1'b0;
        exOp = '0;
        memData = '0;
        commitAllowin = 1'b0;
        rdNumA = '0;
        rdNumB = '0;
        steadyMode = 1'b0;
        offersMade = 0;
        nextPc = 32'h0000_1000;
        repeat (5) @(posedge clk);
        rst <= 1'b1;
        while (acceptedCount < instrTotal) begin
            @(posedge clk);
            driveCycle();
        end
        @(posedge clk);
        commitAllowin <= 1'b1;
        // drain both stages and the trace delay
        while (mRsV || mWbV || traceQ.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        assert (acceptedCount == tracedCount + zeroRetired) else begin
            errors++;
            $display("commit count mismatch: %0d accepted, %0d traced, %0d to register 0",
                     acceptedCount, tracedCount, zeroRetired);
        end
        $display("errors %0d, accepted %0d, traced %0d, register 0 retired %0d",
                 errors, acceptedCount, tracedCount, zeroRetired);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    //////////////////////////////////////////////////
    // model and checks, sampled mid cycle
    //////////////////////////////////////////////////

    task automatic checkTrace();
        flight exp;
        if (traceQ.size() != 0 && traceQ[0].dueEdge == edgeCount) begin
            exp = traceQ.pop_front();
            compareWord("trace_o.wen", 32'hF, 32'(trace.wen));
            compareWord("trace_o.pc", exp.entry.pc, trace.pc);
            compareWord("trace_o.wnum", 32'(exp.entry.writeNum), 32'(trace.wnum));
            compareWord("trace_o.wdata", exp.entry.data, trace.wdata);
            if (exp.steady && (edgeCount - exp.acceptEdge != 3)) begin
                errors++;
                $display("pc %h traced %0d edges after acceptance instead of 3",
                         exp.entry.pc, edgeCount - exp.acceptEdge);
            end
        end else begin
            // destination 0 and idle cycles never show a write
            compareWord("trace_o.wen", 32'h0, 32'(trace.wen));
        end
        if (trace.wen != '0) tracedCount++;
    endtask

    // state for the coming edge
    task automatic advanceModel();
        flight incoming;
        logic  wbMoves;
        wbMoves = !mWbV || commitAllowin;
        if (mWbV && commitAllowin) begin
            if (mWb.entry.writeNum != '0) begin
                arch[mWb.entry.writeNum] = mWb.entry.data;
                // written next edge, traced one edge later
                mWb.dueEdge = edgeCount + 2;
                traceQ.push_back(mWb);
            end else begin
                zeroRetired++;
            end
        end
        if (wbMoves) begin
            mWbV = mRsV;
            mWb = mRs;
        end
        offerAccepted = exValid && expAllowin;
        if (expAllowin) mRsV = exValid;
        if (offerAccepted) begin
            incoming.entry.pc = exOp.pc;
            incoming.entry.writeNum = exOp.writeNum;
            incoming.entry.data = alignLoad(exOp, memData);
            incoming.acceptEdge = edgeCount + 1;
            incoming.dueEdge = 0;
            incoming.steady = steadyMode && commitAllowin;
            mRs = incoming;
            acceptedCount++;
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            mRsV = 1'b0;
            mWbV = 1'b0;
            offerAccepted = 1'b0;
            occupied = 0;
            for (int i = 0; i < pipePkg::gprCount; i++) arch[i] = '0;
        end else begin
            occupied = int'(mRsV) + int'(mWbV);
            // refuse only when full and stuck
            expAllowin = !mRsV || !mWbV || commitAllowin;
            compareWord("exAllowin_o", 32'(expAllowin), 32'(exAllowin));
            compareWord("rdDataA_o", expectRead(rdNumA), rdDataA);
            compareWord("rdDataB_o", expectRead(rdNumB), rdDataB);
            checkTrace();
            advanceModel();
        end
    end

    // edge counter doubles as the run limit
    always @(posedge clk) begin
        edgeCount <= edgeCount + 1;
        if (edgeCount > cycleLimit) begin
            $display("timeout: run still busy after %0d cycles", cycleLimit);
            $display("errors %0d, accepted %0d, traced %0d", errors, acceptedCount, tracedCount);
            $display("Test failures found");
            $finish;
        end
    end

    // wen is all or nothing
    wenShape: assert property (@(posedge clk) disable iff (!rst)
        trace.wen == 4'h0 || trace.wen == 4'hF)
        else begin
            errors++;
            $display("CHECK FAILED t=%0t trace_o.wen expected 0 or f got %h",
                     $time, $sampled(trace.wen));
        end

    // two in flight is the only reason to refuse
    refusedOnlyWhenFull: assert property (@(posedge clk) disable iff (!rst)
        !exAllowin |-> occupied == 2)
        else begin
            errors++;
            $display("CHECK FAILED t=%0t exAllowin_o expected 1 got 0 with %0d in flight",
                     $time, $sampled(occupied));
        end

    // empty pipe right out of reset
    allowinAfterReset: assert property (@(posedge clk) $rose(rst) |-> exAllowin)
        else begin
            errors++;
            $display("CHECK FAILED t=%0t exAllowin_o expected 1 got 0 after reset", $time);
        end

endmodule

`default_nettype wire

/* all.f */
pipePkg.sv
resultStage.sv
writebackStage.sv
regFile.sv
operandBypass.sv
pipeTail.sv
tbClock.sv
pipeTail_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module pipeTail_tb \
    -f all.f --Mdir obj_dir -o simPipeTail
./obj_dir/simPipeTail | tee sim.log

if grep -q "Test failures found" sim.log; then
    exit 1
fi
exit 0
